/* Makefile */
VERILATOR ?= verilator
TOP       ?= control_unit_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* rtl/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic              clock,
    input  logic              rst_n,
    input  logic [15:0]       ir,
    input  logic              z_flag,
    output logic [2:0]        rf_out_a_sel,
    output logic [2:0]        rf_out_b_sel,
    output cu_pkg::reg_fun_t  rf_fun_sel,
    output logic [3:0]        rf_r_sel,
    output cu_pkg::alu_fun_t  alu_fun_sel,
    output logic [1:0]        arf_out_c_sel,
    output logic [1:0]        arf_out_d_sel,
    output cu_pkg::reg_fun_t  arf_fun_sel,
    output logic [3:0]        arf_reg_sel,
    output logic              ir_lh,
    output logic              ir_enable,
    output cu_pkg::reg_fun_t  ir_fun_sel,
    output logic              mem_wr,
    output logic              mem_cs,
    output cu_pkg::mux_src_t  mux_a_sel,
    output cu_pkg::mux_src_t  mux_b_sel,
    output logic              mux_c_sel
);

    cu_pkg::step_t     step;
    logic              last_step;
    logic              a_used;
    logic [2:0]        a_idx;
    logic              b_used;
    logic [2:0]        b_idx;
    logic              dst_used;
    logic [2:0]        dst_idx;
    cu_pkg::reg_fun_t  dst_fun;
    cu_pkg::mux_src_t  dst_src;

    cu_sequencer u_seq (
        .clock     (clock),
        .rst_n     (rst_n),
        .last_step (last_step),
        .step      (step)
    );

    cu_instr_decoder u_dec (
        .step          (step),
        .ir            (ir),
        .z_flag        (z_flag),
        .last_step     (last_step),
        .a_used        (a_used),
        .a_idx         (a_idx),
        .b_used        (b_used),
        .b_idx         (b_idx),
        .dst_used      (dst_used),
        .dst_idx       (dst_idx),
        .dst_fun       (dst_fun),
        .dst_src       (dst_src),
        .alu_fun_sel   (alu_fun_sel),
        .ir_enable     (ir_enable),
        .ir_lh         (ir_lh),
        .ir_fun_sel    (ir_fun_sel),
        .mem_cs        (mem_cs),
        .mem_wr        (mem_wr),
        .arf_out_d_sel (arf_out_d_sel)
    );

    cu_operand_router u_route (
        .a_used        (a_used),
        .a_idx         (a_idx),
        .b_used        (b_used),
        .b_idx         (b_idx),
        .dst_used      (dst_used),
        .dst_idx       (dst_idx),
        .dst_fun       (dst_fun),
        .dst_src       (dst_src),
        .rf_out_a_sel  (rf_out_a_sel),
        .rf_out_b_sel  (rf_out_b_sel),
        .rf_fun_sel    (rf_fun_sel),
        .rf_r_sel      (rf_r_sel),
        .arf_out_c_sel (arf_out_c_sel),
        .arf_fun_sel   (arf_fun_sel),
        .arf_reg_sel   (arf_reg_sel),
        .mux_a_sel     (mux_a_sel),
        .mux_b_sel     (mux_b_sel),
        .mux_c_sel     (mux_c_sel)
    );

endmodule

`default_nettype wire

/* rtl/cu_instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_instr_decoder (
    input  cu_pkg::step_t      step,
    input  logic [15:0]        ir,
    input  logic               z_flag,
    output logic               last_step,
    output logic               a_used,
    output logic [2:0]         a_idx,
    output logic               b_used,
    output logic [2:0]         b_idx,
    output logic               dst_used,
    output logic [2:0]         dst_idx,
    output cu_pkg::reg_fun_t   dst_fun,
    output cu_pkg::mux_src_t   dst_src,
    output cu_pkg::alu_fun_t   alu_fun_sel,
    output logic               ir_enable,
    output logic               ir_lh,
    output cu_pkg::reg_fun_t   ir_fun_sel,
    output logic               mem_cs,
    output logic               mem_wr,
    output logic [1:0]         arf_out_d_sel
);

    // Address-file output D codes
    localparam logic [1:0] ARF_D_AR = 2'b00;
    localparam logic [1:0] ARF_D_PC = 2'b11;

    cu_pkg::opcode_t opcode;
    logic            direct;
    logic [2:0]      dst_field;
    logic [2:0]      src1_field;
    logic [2:0]      src2_field;
    logic [2:0]      rsel_idx;

    assign opcode     = cu_pkg::opcode_t'(ir[cu_pkg::OPCODE_LSB +: 4]);
    assign direct     = ir[cu_pkg::MODE_BIT];
    assign dst_field  = ir[cu_pkg::DST_LSB +: 3];
    assign src1_field = ir[cu_pkg::SRC1_LSB +: 3];
    assign src2_field = ir[cu_pkg::SRC2_LSB +: 3];
    assign rsel_idx   = {1'b0, ir[cu_pkg::RSEL_LSB +: 2]};  // R1..R4 only

    always_comb begin
        last_step     = 1'b1;
        a_used        = 1'b0;
        a_idx         = 3'd0;
        b_used        = 1'b0;
        b_idx         = 3'd0;
        dst_used      = 1'b0;
        dst_idx       = 3'd0;
        dst_fun       = cu_pkg::FUN_HOLD;
        dst_src       = cu_pkg::MUX_ALU;
        alu_fun_sel   = cu_pkg::ALU_PASS_A;
        ir_enable     = 1'b0;
        ir_lh         = 1'b0;
        ir_fun_sel    = cu_pkg::FUN_HOLD;
        mem_cs        = 1'b0;
        mem_wr        = 1'b0;
        arf_out_d_sel = ARF_D_AR;
        case (step)
            cu_pkg::STEP_FETCH_LO, cu_pkg::STEP_FETCH_HI: begin
                ir_enable     = 1'b1;
                ir_fun_sel    = cu_pkg::FUN_LOAD;
                ir_lh         = (step == cu_pkg::STEP_FETCH_HI);
                arf_out_d_sel = ARF_D_PC;
                dst_used      = 1'b1;
                dst_idx       = cu_pkg::IDX_PC;
                dst_fun       = cu_pkg::FUN_INC;  // PC steps in both fetch cycles
            end
            cu_pkg::STEP_EXEC_1: begin
                case (opcode)
                    cu_pkg::OP_AND, cu_pkg::OP_OR, cu_pkg::OP_NOT, cu_pkg::OP_ADD,
                    cu_pkg::OP_SUB, cu_pkg::OP_LSR, cu_pkg::OP_LSL, cu_pkg::OP_MOV: begin
                        a_used   = 1'b1;
                        a_idx    = src1_field;
                        b_used   = (opcode == cu_pkg::OP_AND) || (opcode == cu_pkg::OP_OR)
                                   || (opcode == cu_pkg::OP_ADD) || (opcode == cu_pkg::OP_SUB);
                        b_idx    = src2_field;
                        dst_used = 1'b1;
                        dst_idx  = dst_field;
                        dst_fun  = cu_pkg::FUN_LOAD;
                        case (opcode)
                            cu_pkg::OP_AND: alu_fun_sel = cu_pkg::ALU_AND;
                            cu_pkg::OP_OR:  alu_fun_sel = cu_pkg::ALU_OR;
                            cu_pkg::OP_NOT: alu_fun_sel = cu_pkg::ALU_NOT_A;
                            cu_pkg::OP_ADD: alu_fun_sel = cu_pkg::ALU_ADD;
                            cu_pkg::OP_SUB: alu_fun_sel = cu_pkg::ALU_SUB;
                            cu_pkg::OP_LSR: alu_fun_sel = cu_pkg::ALU_LSR;
                            cu_pkg::OP_LSL: alu_fun_sel = cu_pkg::ALU_LSL;
                            default:        alu_fun_sel = cu_pkg::ALU_PASS_A;  // MOV
                        endcase
                    end
                    cu_pkg::OP_BRA, cu_pkg::OP_BNE, cu_pkg::OP_LD, cu_pkg::OP_ST: begin
                        if (!(opcode == cu_pkg::OP_BNE && z_flag)) begin
                            dst_used = 1'b1;
                            dst_fun  = cu_pkg::FUN_LOAD;
                            dst_src  = cu_pkg::MUX_IR;
                            if (direct || opcode == cu_pkg::OP_ST) begin
                                last_step = 1'b0;  // Address byte goes to AR first
                                dst_idx   = cu_pkg::IDX_AR;
                            end else if (opcode == cu_pkg::OP_LD) begin
                                dst_idx = rsel_idx;
                            end else begin
                                dst_idx = cu_pkg::IDX_PC;
                            end
                        end
                    end
                    default: begin
                        // Retired opcodes idle for one execute cycle
                    end
                endcase
            end
            default: begin
                mem_cs        = 1'b1;
                arf_out_d_sel = ARF_D_AR;  // Memory at AR
                case (opcode)
                    cu_pkg::OP_ST: begin
                        mem_wr      = 1'b1;
                        b_used      = 1'b1;
                        b_idx       = rsel_idx;
                        alu_fun_sel = cu_pkg::ALU_PASS_B;
                    end
                    cu_pkg::OP_LD: begin
                        dst_used = 1'b1;
                        dst_idx  = rsel_idx;
                        dst_fun  = cu_pkg::FUN_LOAD;
                        dst_src  = cu_pkg::MUX_MEM;
                    end
                    default: begin
                        dst_used = 1'b1;
                        dst_idx  = cu_pkg::IDX_PC;  // BRA and taken BNE
                        dst_fun  = cu_pkg::FUN_LOAD;
                        dst_src  = cu_pkg::MUX_MEM;
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/cu_operand_router.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_operand_router (
    input  logic              a_used,
    input  logic [2:0]        a_idx,
    input  logic              b_used,
    input  logic [2:0]        b_idx,
    input  logic              dst_used,
    input  logic [2:0]        dst_idx,
    input  cu_pkg::reg_fun_t  dst_fun,
    input  cu_pkg::mux_src_t  dst_src,
    output logic [2:0]        rf_out_a_sel,
    output logic [2:0]        rf_out_b_sel,
    output cu_pkg::reg_fun_t  rf_fun_sel,
    output logic [3:0]        rf_r_sel,
    output logic [1:0]        arf_out_c_sel,
    output cu_pkg::reg_fun_t  arf_fun_sel,
    output logic [3:0]        arf_reg_sel,
    output cu_pkg::mux_src_t  mux_a_sel,
    output cu_pkg::mux_src_t  mux_b_sel,
    output logic              mux_c_sel
);

    // Address-file output C codes
    localparam logic [1:0] ARF_C_AR = 2'b00;
    localparam logic [1:0] ARF_C_SP = 2'b01;
    localparam logic [1:0] ARF_C_PC = 2'b11;

    logic a_gen;
    logic b_gen;
    logic dst_gen;

    assign a_gen   = (a_idx < 3'd4);
    assign b_gen   = (b_idx < 3'd4);
    assign dst_gen = (dst_idx < 3'd4);

    // Operand A comes from the general file or, through mux C, the address file
    always_comb begin
        rf_out_a_sel  = 3'd0;
        arf_out_c_sel = 2'b00;
        mux_c_sel     = 1'b0;
        if (a_used) begin
            if (a_gen) begin
                rf_out_a_sel = a_idx + 3'd4;
            end else begin
                mux_c_sel = 1'b1;
                case (a_idx)
                    cu_pkg::IDX_SP: arf_out_c_sel = ARF_C_SP;
                    cu_pkg::IDX_AR: arf_out_c_sel = ARF_C_AR;
                    default:        arf_out_c_sel = ARF_C_PC;
                endcase
            end
        end
    end

    // Operand B has no address-file path
    always_comb begin
        rf_out_b_sel = 3'd0;
        if (b_used && b_gen) begin
            rf_out_b_sel = b_idx + 3'd4;
        end
    end

    // Writes to R1..R4 go through mux A, to SP/AR/PC through mux B
    always_comb begin
        rf_fun_sel  = cu_pkg::FUN_HOLD;
        rf_r_sel    = 4'b0000;
        mux_a_sel   = cu_pkg::MUX_ALU;
        arf_fun_sel = cu_pkg::FUN_HOLD;
        arf_reg_sel = 4'b0000;
        mux_b_sel   = cu_pkg::MUX_ALU;
        if (dst_used) begin
            if (dst_gen) begin
                rf_fun_sel = dst_fun;
                mux_a_sel  = dst_src;
                rf_r_sel   = 4'b1000 >> dst_idx[1:0];  // R1 is the top bit
            end else begin
                arf_fun_sel = dst_fun;
                mux_b_sel   = dst_src;
                case (dst_idx)
                    cu_pkg::IDX_SP: arf_reg_sel = 4'b0010;
                    cu_pkg::IDX_AR: arf_reg_sel = 4'b0100;
                    default:        arf_reg_sel = 4'b1000;  // PC
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/cu_pkg.sv */
`default_nettype none

package cu_pkg;

    // Instruction step, two fetch cycles then up to two execute cycles
    typedef enum logic [1:0] {
        STEP_FETCH_LO = 2'd0,
        STEP_FETCH_HI = 2'd1,
        STEP_EXEC_1   = 2'd2,
        STEP_EXEC_2   = 2'd3
    } step_t;

    // Opcode field, IR[15:12]
    typedef enum logic [3:0] {
        OP_AND  = 4'd0,
        OP_OR   = 4'd1,
        OP_NOT  = 4'd2,
        OP_ADD  = 4'd3,
        OP_SUB  = 4'd4,
        OP_LSR  = 4'd5,
        OP_LSL  = 4'd6,
        OP_INC  = 4'd7,   // Retired, decodes as no-op
        OP_DEC  = 4'd8,   // Retired
        OP_BRA  = 4'd9,
        OP_BNE  = 4'd10,
        OP_MOV  = 4'd11,
        OP_LD   = 4'd12,
        OP_ST   = 4'd13,
        OP_PULL = 4'd14,  // Retired
        OP_PUSH = 4'd15   // Retired
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_PASS_A = 4'd0,
        ALU_PASS_B = 4'd1,
        ALU_NOT_A  = 4'd2,
        ALU_ADD    = 4'd4,
        ALU_SUB    = 4'd5,
        ALU_AND    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_LSL    = 4'd11,
        ALU_LSR    = 4'd12
    } alu_fun_t;

    // Shared by the general file, the address file and the IR
    typedef enum logic [1:0] {
        FUN_HOLD = 2'd0,
        FUN_LOAD = 2'd1,
        FUN_DEC  = 2'd2,
        FUN_INC  = 2'd3
    } reg_fun_t;

    typedef enum logic [1:0] {
        MUX_ALU = 2'd0,
        MUX_ARF = 2'd1,
        MUX_IR  = 2'd2,
        MUX_MEM = 2'd3
    } mux_src_t;

    // Instruction field positions
    localparam int OPCODE_LSB = 12;
    localparam int DST_LSB    = 8;
    localparam int SRC1_LSB   = 4;
    localparam int SRC2_LSB   = 0;
    localparam int MODE_BIT   = 10;
    localparam int RSEL_LSB   = 8;   // 2 bits
    localparam int ADDR_LSB   = 0;   // 8 bits

    // Register indices above the general file, 7 aliases PC
    localparam logic [2:0] IDX_SP = 3'd4;
    localparam logic [2:0] IDX_AR = 3'd5;
    localparam logic [2:0] IDX_PC = 3'd6;

endpackage

`default_nettype wire

/* rtl/cu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_sequencer (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           last_step,
    output cu_pkg::step_t  step
);

    cu_pkg::step_t step_next;

    always_comb begin
        case (step)
            cu_pkg::STEP_FETCH_LO: step_next = cu_pkg::STEP_FETCH_HI;
            cu_pkg::STEP_FETCH_HI: step_next = cu_pkg::STEP_EXEC_1;
            cu_pkg::STEP_EXEC_1: begin
                if (last_step) begin
                    step_next = cu_pkg::STEP_FETCH_LO;  // Short instruction done
                end else begin
                    step_next = cu_pkg::STEP_EXEC_2;
                end
            end
            default: step_next = cu_pkg::STEP_FETCH_LO;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            step <= cu_pkg::STEP_FETCH_LO;
        end else begin
            step <= step_next;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
rtl/cu_pkg.sv
rtl/cu_sequencer.sv
rtl/cu_instr_decoder.sv
rtl/cu_operand_router.sv
rtl/control_unit.sv
verification/control_unit_chk.sv
verification/control_unit_tb.sv

/* verification/control_unit_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit_chk (
    input logic clock,
    input logic rst_n,
    input logic ir_enable,
    input logic ir_lh,
    input logic mem_cs,
    input logic mem_wr
);

    int unsigned violations = 0;

    wr_needs_cs: assert property (@(posedge clock) disable iff (!rst_n)
        mem_wr |-> mem_cs)
        else begin
            violations++;
            $error("mem_wr high while mem_cs is low");
        end

    // Fetch is two cycles, never three; reset itself holds FETCH_LO
    fetch_two_cycles: assert property (@(posedge clock) disable iff (!rst_n)
        (ir_enable && $past(ir_enable) && $past(rst_n)) |-> ##1 !ir_enable)
        else begin
            violations++;
            $error("ir_enable high for more than two cycles in a row");
        end

    no_mem_after_fetch_lo: assert property (@(posedge clock) disable iff (!rst_n)
        (ir_enable && !ir_lh) |=> !mem_cs)
        else begin
            violations++;
            $error("mem_cs high in the cycle after the low-byte fetch");
        end

endmodule

bind control_unit control_unit_chk chk_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .ir_enable (ir_enable),
    .ir_lh     (ir_lh),
    .mem_cs    (mem_cs),
    .mem_wr    (mem_wr)
);

`default_nettype wire

/* verification/control_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit_tb;

    localparam int NUM_INSTR   = 300;
    localparam int NUM_FORCED  = 64;                   // 16 opcodes x 2 modes x 2 z_flag
    localparam int CYCLE_LIMIT = NUM_INSTR * 4 + 200;  // Longest instruction is 4 cycles

    logic              clock;
    logic              rst_n;
    logic [15:0]       ir;
    logic              z_flag;
    logic [2:0]        rf_out_a_sel;
    logic [2:0]        rf_out_b_sel;
    cu_pkg::reg_fun_t  rf_fun_sel;
    logic [3:0]        rf_r_sel;
    cu_pkg::alu_fun_t  alu_fun_sel;
    logic [1:0]        arf_out_c_sel;
    logic [1:0]        arf_out_d_sel;
    cu_pkg::reg_fun_t  arf_fun_sel;
    logic [3:0]        arf_reg_sel;
    logic              ir_lh;
    logic              ir_enable;
    cu_pkg::reg_fun_t  ir_fun_sel;
    logic              mem_wr;
    logic              mem_cs;
    cu_pkg::mux_src_t  mux_a_sel;
    cu_pkg::mux_src_t  mux_b_sel;
    logic              mux_c_sel;

    integer seed;
    int     error_count;
    int     check_count;
    int     cycle_count;

    // Expected control values for the current step
    logic [2:0] exp_rf_a;
    logic [2:0] exp_rf_b;
    logic [1:0] exp_rf_fun;
    logic [3:0] exp_rf_r;
    logic [3:0] exp_alu;
    logic [1:0] exp_arf_c;
    logic [1:0] exp_arf_d;
    logic [1:0] exp_arf_fun;
    logic [3:0] exp_arf_reg;
    logic       exp_ir_lh;
    logic       exp_ir_en;
    logic [1:0] exp_ir_fun;
    logic       exp_mem_wr;
    logic       exp_mem_cs;
    logic [1:0] exp_mux_a;
    logic [1:0] exp_mux_b;
    logic       exp_mux_c;

    control_unit control_unit_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .ir            (ir),
        .z_flag        (z_flag),
        .rf_out_a_sel  (rf_out_a_sel),
        .rf_out_b_sel  (rf_out_b_sel),
        .rf_fun_sel    (rf_fun_sel),
        .rf_r_sel      (rf_r_sel),
        .alu_fun_sel   (alu_fun_sel),
        .arf_out_c_sel (arf_out_c_sel),
        .arf_out_d_sel (arf_out_d_sel),
        .arf_fun_sel   (arf_fun_sel),
        .arf_reg_sel   (arf_reg_sel),
        .ir_lh         (ir_lh),
        .ir_enable     (ir_enable),
        .ir_fun_sel    (ir_fun_sel),
        .mem_wr        (mem_wr),
        .mem_cs        (mem_cs),
        .mux_a_sel     (mux_a_sel),
        .mux_b_sel     (mux_b_sel),
        .mux_c_sel     (mux_c_sel)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Direct BRA, LD, taken BNE and every ST
    function automatic logic needs_exec_2(input logic [15:0] word, input logic z);
        logic [3:0] op;
        op = word[15:12];
        if (op == cu_pkg::OP_ST) begin
            return 1'b1;
        end
        if (!word[10]) begin
            return 1'b0;
        end
        return (op == cu_pkg::OP_BRA) || (op == cu_pkg::OP_LD) || (op == cu_pkg::OP_BNE && !z);
    endfunction

    task automatic set_idle();
        exp_rf_a    = 3'd0;
        exp_rf_b    = 3'd0;
        exp_rf_fun  = cu_pkg::FUN_HOLD;
        exp_rf_r    = 4'b0000;
        exp_alu     = cu_pkg::ALU_PASS_A;
        exp_arf_c   = 2'b00;
        exp_arf_d   = 2'b00;
        exp_arf_fun = cu_pkg::FUN_HOLD;
        exp_arf_reg = 4'b0000;
        exp_ir_lh   = 1'b0;
        exp_ir_en   = 1'b0;
        exp_ir_fun  = cu_pkg::FUN_HOLD;
        exp_mem_wr  = 1'b0;
        exp_mem_cs  = 1'b0;
        exp_mux_a   = cu_pkg::MUX_ALU;
        exp_mux_b   = cu_pkg::MUX_ALU;
        exp_mux_c   = 1'b0;
    endtask

    task automatic write_dest(input logic [2:0] idx, input logic [1:0] src);
        if (idx < 3'd4) begin
            exp_rf_fun = cu_pkg::FUN_LOAD;
            exp_mux_a  = src;
            case (idx[1:0])
                2'd0:    exp_rf_r = 4'b1000;  // R1
                2'd1:    exp_rf_r = 4'b0100;
                2'd2:    exp_rf_r = 4'b0010;
                default: exp_rf_r = 4'b0001;
            endcase
        end else begin
            exp_arf_fun = cu_pkg::FUN_LOAD;
            exp_mux_b   = src;
            case (idx)
                3'd4:    exp_arf_reg = 4'b0010;  // SP
                3'd5:    exp_arf_reg = 4'b0100;  // AR
                default: exp_arf_reg = 4'b1000;  // PC
            endcase
        end
    endtask

    task automatic alu_expect(input logic [15:0] word);
        logic [3:0] op;
        logic [2:0] src1;
        logic [2:0] src2;
        op   = word[15:12];
        src1 = word[6:4];
        src2 = word[2:0];
        case (op)
            cu_pkg::OP_AND: exp_alu = cu_pkg::ALU_AND;
            cu_pkg::OP_OR:  exp_alu = cu_pkg::ALU_OR;
            cu_pkg::OP_NOT: exp_alu = cu_pkg::ALU_NOT_A;
            cu_pkg::OP_ADD: exp_alu = cu_pkg::ALU_ADD;
            cu_pkg::OP_SUB: exp_alu = cu_pkg::ALU_SUB;
            cu_pkg::OP_LSR: exp_alu = cu_pkg::ALU_LSR;
            cu_pkg::OP_LSL: exp_alu = cu_pkg::ALU_LSL;
            default:        exp_alu = cu_pkg::ALU_PASS_A;  // MOV
        endcase
        if (src1 < 3'd4) begin
            exp_rf_a = src1 + 3'd4;
        end else begin
            exp_mux_c = 1'b1;
            case (src1)
                3'd4:    exp_arf_c = 2'b01;
                3'd5:    exp_arf_c = 2'b00;
                default: exp_arf_c = 2'b11;
            endcase
        end
        if ((op == cu_pkg::OP_AND || op == cu_pkg::OP_OR || op == cu_pkg::OP_ADD
             || op == cu_pkg::OP_SUB) && src2 < 3'd4) begin
            exp_rf_b = src2 + 3'd4;  // No address-file path on B
        end
        write_dest(word[10:8], cu_pkg::MUX_ALU);
    endtask

    task automatic compute_expected(input cu_pkg::step_t st, input logic [15:0] word,
                                    input logic z);
        logic [3:0] op;
        logic [1:0] rsel;
        logic       alu_op;
        op     = word[15:12];
        rsel   = word[9:8];
        alu_op = (op <= cu_pkg::OP_LSL) || (op == cu_pkg::OP_MOV);
        set_idle();
        case (st)
            cu_pkg::STEP_FETCH_LO, cu_pkg::STEP_FETCH_HI: begin
                exp_ir_en   = 1'b1;
                exp_ir_fun  = cu_pkg::FUN_LOAD;
                exp_ir_lh   = (st == cu_pkg::STEP_FETCH_HI);
                exp_arf_d   = 2'b11;  // PC
                exp_arf_fun = cu_pkg::FUN_INC;
                exp_arf_reg = 4'b1000;
            end
            cu_pkg::STEP_EXEC_1: begin
                if (alu_op) begin
                    alu_expect(word);
                end else if (needs_exec_2(word, z)) begin
                    write_dest(cu_pkg::IDX_AR, cu_pkg::MUX_IR);
                end else if (op == cu_pkg::OP_BRA || (op == cu_pkg::OP_BNE && !z)) begin
                    write_dest(cu_pkg::IDX_PC, cu_pkg::MUX_IR);
                end else if (op == cu_pkg::OP_LD) begin
                    write_dest({1'b0, rsel}, cu_pkg::MUX_IR);
                end
            end
            default: begin
                exp_mem_cs = 1'b1;
                exp_arf_d  = 2'b00;  // AR
                if (op == cu_pkg::OP_ST) begin
                    exp_mem_wr = 1'b1;
                    exp_rf_b   = {1'b0, rsel} + 3'd4;
                    exp_alu    = cu_pkg::ALU_PASS_B;
                end else if (op == cu_pkg::OP_LD) begin
                    write_dest({1'b0, rsel}, cu_pkg::MUX_MEM);
                end else begin
                    write_dest(cu_pkg::IDX_PC, cu_pkg::MUX_MEM);
                end
            end
        endcase
    endtask

    task automatic check_field(input string name, input logic [3:0] expected,
                               input logic [3:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("[FAIL] %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        check_field("rf_out_a_sel", 4'(exp_rf_a), 4'(rf_out_a_sel));
        check_field("rf_out_b_sel", 4'(exp_rf_b), 4'(rf_out_b_sel));
        check_field("rf_fun_sel", 4'(exp_rf_fun), 4'(rf_fun_sel));
        check_field("rf_r_sel", exp_rf_r, rf_r_sel);
        check_field("alu_fun_sel", exp_alu, 4'(alu_fun_sel));
        check_field("arf_out_c_sel", 4'(exp_arf_c), 4'(arf_out_c_sel));
        check_field("arf_out_d_sel", 4'(exp_arf_d), 4'(arf_out_d_sel));
        check_field("arf_fun_sel", 4'(exp_arf_fun), 4'(arf_fun_sel));
        check_field("arf_reg_sel", exp_arf_reg, arf_reg_sel);
        check_field("ir_lh", 4'(exp_ir_lh), 4'(ir_lh));
        check_field("ir_enable", 4'(exp_ir_en), 4'(ir_enable));
        check_field("ir_fun_sel", 4'(exp_ir_fun), 4'(ir_fun_sel));
        check_field("mem_wr", 4'(exp_mem_wr), 4'(mem_wr));
        check_field("mem_cs", 4'(exp_mem_cs), 4'(mem_cs));
        check_field("mux_a_sel", 4'(exp_mux_a), 4'(mux_a_sel));
        check_field("mux_b_sel", 4'(exp_mux_b), 4'(mux_b_sel));
        check_field("mux_c_sel", 4'(exp_mux_c), 4'(mux_c_sel));
    endtask

    // Called on the edge that enters FETCH_LO, returns on the next such edge
    task automatic run_instruction(input logic [15:0] word, input logic z);
        cu_pkg::step_t model;
        cu_pkg::step_t next;
        ir     <= word;
        z_flag <= z;
        model = cu_pkg::STEP_FETCH_LO;
        do begin
            @(negedge clock);
            compute_expected(model, word, z);
            check_outputs();
            case (model)
                cu_pkg::STEP_FETCH_LO: next = cu_pkg::STEP_FETCH_HI;
                cu_pkg::STEP_FETCH_HI: next = cu_pkg::STEP_EXEC_1;
                cu_pkg::STEP_EXEC_1: begin
                    next = needs_exec_2(word, z) ? cu_pkg::STEP_EXEC_2 : cu_pkg::STEP_FETCH_LO;
                end
                default: next = cu_pkg::STEP_FETCH_LO;
            endcase
            @(posedge clock);
            model = next;
        end while (model != cu_pkg::STEP_FETCH_LO);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        integer     rnd;
        logic [15:0] word;
        rst_n       = 1'b0;
        ir          = 16'h0000;
        z_flag      = 1'b0;
        seed        = 32'h8d17d03b;
        error_count = 0;
        check_count = 0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        // Mode bit doubles as dst bit 2, so ALU writes land on both files
        for (int k = 0; k < NUM_FORCED; k++) begin
            rnd         = $random(seed);
            word        = rnd[15:0];
            word[15:12] = k[5:2];
            word[10]    = k[1];
            run_instruction(word, k[0]);
        end
        for (int k = NUM_FORCED; k < NUM_INSTR; k++) begin
            rnd  = $random(seed);
            word = rnd[15:0];
            rnd  = $random(seed);
            run_instruction(word, rnd[0]);
        end
        $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
                 check_count, error_count, control_unit_i.chk_i.violations);
        if (error_count == 0 && control_unit_i.chk_i.violations == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
